//--- files.f
+incdir+test
source/mem_pkg.sv
source/mem_lsu.sv
source/mem_stage.sv
source/mem_pipe_reg.sv
source/mem_response.sv
source/mem_subsystem.sv
test/tb_mem_subsystem.sv

//--- test/tb_mem_model.svh
// Reference model for the memory subsystem testbench.
// Data memory and MMIO are modeled byte by byte from the op stream.
// MMIO stores are whole words; unwritten words read a full-address fill.

`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

typedef struct packed {
    fu_t       fu;
    uop_t      uop;
    reg_addr_t rd;
    xlen_t     a;              // Address or result
    xlen_t     b;              // Store data
} op_t;

typedef struct packed {
    logic        wen;
    reg_addr_t   rd;
    xlen_t       data;
    logic        trap;
    cause_t      cause;
    logic [31:0] cyc;          // Cycle of s3 transfer
} wb_exp_t;

xlen_t ref_mem [xlen_t];       // Model view, keyed by word address
xlen_t bus_mem [xlen_t];       // Responder view, written via dmem strobes
xlen_t ref_mmio [16];
xlen_t dev_mmio [16];

function automatic xlen_t fill_word(input xlen_t waddr);
    return (waddr * 32'h9E37_79B1) ^ 32'h5C3A_A3C5;  // Mixes every address bit
endfunction

function automatic logic in_mmio(input xlen_t addr);
    return (addr & MMIO_BASE_MASK) == MMIO_BASE_ADDR;
endfunction

function automatic logic misaligned(input op_t op);
    logic [1:0] size;
    size = op.uop[UOP_SIZE_LO +: 2];
    return (size == LSU_HALF && op.a[0]) || (size == LSU_WORD && op.a[1:0] != 2'b00);
endfunction

function automatic xlen_t ref_word(input xlen_t waddr);
    return ref_mem.exists(waddr) ? ref_mem[waddr] : fill_word(waddr);
endfunction

function automatic logic [7:0] ref_byte(input xlen_t addr);
    xlen_t w;
    if (in_mmio(addr))
        w = ref_mmio[addr[5:2]];
    else
        w = ref_word({addr[31:2], 2'b00});
    return w[8 * addr[1:0] +: 8];
endfunction

// Expected writeback of one op, stores update the model on the way
function automatic wb_exp_t ref_apply(input op_t op);
    wb_exp_t e;
    int      nbytes;
    int      i;
    xlen_t   a;
    xlen_t   w;
    e      = '0;
    e.rd   = op.rd;
    nbytes = 1 << op.uop[UOP_SIZE_LO +: 2];
    if (op.fu != FU_LSU) begin
        e.wen  = 1'b1;                           // Operand A straight to rd
        e.data = op.a;
    end else if (misaligned(op)) begin
        e.trap  = 1'b1;
        e.cause = op.uop[UOP_LOAD] ? TRAP_LDALIGN : TRAP_STALIGN;
    end else if (op.uop[UOP_STORE]) begin
        if (in_mmio(op.a)) begin
            ref_mmio[op.a[5:2]] = op.b;
        end else begin
            for (i = 0; i < nbytes; i++) begin
                a = op.a + xlen_t'(i);
                w = ref_word({a[31:2], 2'b00});
                w[8 * a[1:0] +: 8] = op.b[8 * i +: 8];
                ref_mem[{a[31:2], 2'b00}] = w;
            end
        end
    end else begin
        e.wen = 1'b1;
        for (i = 0; i < nbytes; i++)
            e.data[8 * i +: 8] = ref_byte(op.a + xlen_t'(i));
        if (op.uop[UOP_SIGNED])
            for (i = 8 * nbytes; i < 32; i++)
                e.data[i] = e.data[8 * nbytes - 1];  // Sign fill
    end
    return e;
endfunction

function automatic xlen_t bus_read(input xlen_t waddr);
    return bus_mem.exists(waddr) ? bus_mem[waddr] : fill_word(waddr);
endfunction

function automatic void bus_write(input xlen_t waddr, input strb_t strb, input xlen_t data);
    xlen_t w;
    int    i;
    w = bus_read(waddr);
    for (i = 0; i < 4; i++)
        if (strb[i]) w[8 * i +: 8] = data[8 * i +: 8];  // Merge by lane
    bus_mem[waddr] = w;
endfunction

`endif

//--- test/tb_mem_subsystem.sv
// Testbench for the memory subsystem. Random ops from a fixed seed are
// checked in issue order against the model in tb_mem_model.svh.
// Data accesses stay in a 64 byte window at 0x100, MMIO in 0x1000..0x103F.

`timescale 1ns/100ps

module tb_mem_subsystem import mem_pkg::*; ();

    localparam int DRAIN_LIMIT = 4000;   // Cycles allowed per test

    logic      g_clk;
    logic      g_resetn;
    logic      s3_valid     = 1'b0;
    reg_addr_t s3_rd        = '0;
    xlen_t     s3_opr_a     = '0;
    xlen_t     s3_opr_b     = '0;
    uop_t      s3_uop       = '0;
    fu_t       s3_fu        = '0;
    logic      s3_trap      = 1'b0;      // Execute never traps here
    logic      s3_busy;
    logic      hold_lsu_req = 1'b0;
    logic      dmem_req;
    logic      dmem_wen;
    strb_t     dmem_strb;
    xlen_t     dmem_addr;
    xlen_t     dmem_wdata;
    logic      dmem_gnt     = 1'b0;
    logic      dmem_recv    = 1'b0;
    xlen_t     dmem_rdata   = '0;
    logic      mmio_en;
    logic      mmio_wen;
    xlen_t     mmio_addr;
    xlen_t     mmio_wdata;
    xlen_t     mmio_rdata   = '0;
    logic      wb_valid;
    logic      wb_wen;
    reg_addr_t wb_rd;
    xlen_t     wb_wdata;
    logic      wb_trap;
    cause_t    wb_cause;

    `include "tb_mem_model.svh"

    op_t        op_q [$];                // Ops waiting for s3
    wb_exp_t    exp_q [$];               // Expected writebacks in order
    xlen_t      rdata_q [$];             // Load data in flight
    int         due_q [$];               // Return cycle of each load
    op_t        cur_op       = '0;
    logic       op_live      = 1'b0;     // cur_op sits in s3
    int         cyc          = 0;
    int         gnt_wait     = 0;
    logic       req_wait     = 1'b0;     // Request seen, not granted yet
    logic       held_wen;
    strb_t      held_strb;
    xlen_t      held_addr;
    xlen_t      held_wdata;
    logic       mmio_rd_pend = 1'b0;
    logic [3:0] mmio_rd_idx  = '0;
    logic       running      = 1'b0;
    logic       rand_stall   = 1'b0;
    logic       lat_check    = 1'b0;
    logic       timed_out    = 1'b0;
    string      test_name    = "reset";
    int         errors       = 0;
    int         checks       = 0;
    int         tests_run    = 0;
    int         tests_failed = 0;

    mem_subsystem dut (.*);

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;
    end

    task automatic report_value(input string what, input xlen_t exp, input xlen_t act);
        $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic report_event(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        errors++;
    endtask

    // Kind 0 pass-through, 1 data ld/st, 2 misaligned, 3 MMIO, 4 any
    function automatic op_t random_op(input int kind);
        op_t        op;
        int         k;
        logic       store;
        logic [1:0] size;
        op    = '0;
        op.rd = reg_addr_t'($urandom);
        op.b  = $urandom;
        k     = (kind == 4) ? int'($urandom_range(0, 3)) : kind;
        if (k == 0) begin
            op.a   = $urandom;
            op.uop = uop_t'($urandom);           // Ignored for pass-through
        end else begin
            store = (k == 3) ? ($urandom_range(0, 2) == 0) : 1'($urandom_range(0, 1));
            size  = (k == 2) ? 2'($urandom_range(1, 2)) : 2'($urandom_range(0, 2));
            if (k == 3 && store) size = LSU_WORD; // MMIO device takes words
            op.fu                    = FU_LSU;
            op.uop[UOP_LOAD]         = !store;
            op.uop[UOP_STORE]        = store;
            op.uop[UOP_SIZE_LO +: 2] = size;
            op.uop[UOP_SIGNED]       = !store && $urandom_range(0, 1);
            op.a = (k == 3 ? MMIO_BASE_ADDR : 32'h0000_0100) + $urandom_range(0, 63);
            if (k != 2)
                op.a = op.a & ~((xlen_t'(1) << size) - 1);
            else if (size == LSU_HALF)
                op.a[0] = 1'b1;
            else
                op.a[1:0] = 2'($urandom_range(1, 3));
        end
        return op;
    endfunction

    task automatic check_wb();
        wb_exp_t e;
        if (exp_q.size() == 0) begin
            report_event("wb_valid with no instruction outstanding");
        end else begin
            e = exp_q.pop_front();
            checks++;
            if (wb_trap !== e.trap) report_value("wb_trap", xlen_t'(e.trap), xlen_t'(wb_trap));
            if (e.trap && wb_cause !== e.cause)
                report_value("wb_cause", xlen_t'(e.cause), xlen_t'(wb_cause));
            if (wb_wen !== e.wen) report_value("wb_wen", xlen_t'(e.wen), xlen_t'(wb_wen));
            if (e.wen && wb_rd !== e.rd) report_value("wb_rd", xlen_t'(e.rd), xlen_t'(wb_rd));
            if (e.wen && wb_wdata !== e.data) report_value("wb_wdata", e.data, wb_wdata);
            if (lat_check && cyc - e.cyc != 2)
                report_value("latency", 32'd2, xlen_t'(cyc - e.cyc));
        end
    endtask

    // ------------------------------------------------------------------
    // Per-cycle sampling just before the rising edge
    // ------------------------------------------------------------------

    task automatic sample_cycle();
        logic    xfer;
        wb_exp_t e;
        xfer = s3_valid && !s3_busy;
        if (req_wait && (!dmem_req || dmem_wen !== held_wen || dmem_strb !== held_strb ||
                         dmem_addr !== held_addr || dmem_wdata !== held_wdata))
            report_event("dmem request changed or dropped before dmem_gnt");
        req_wait   = dmem_req && !dmem_gnt;
        held_wen   = dmem_wen;
        held_strb  = dmem_strb;
        held_addr  = dmem_addr;
        held_wdata = dmem_wdata;
        if (dmem_req && dmem_gnt) begin
            if (dmem_wen) begin
                bus_write(dmem_addr, dmem_strb, dmem_wdata);
            end else begin
                rdata_q.push_back(bus_read(dmem_addr));
                due_q.push_back(cyc + int'($urandom_range(1, 4)));
            end
            gnt_wait = $urandom_range(0, 3);        // Delay for the next request
        end else if (dmem_req && gnt_wait > 0) begin
            gnt_wait--;
        end
        mmio_rd_pend = mmio_en && !mmio_wen;         // Answer next cycle
        mmio_rd_idx  = mmio_addr[5:2];
        if (mmio_en && mmio_wen) dev_mmio[mmio_addr[5:2]] = mmio_wdata;
        if (op_live && cur_op.fu == FU_LSU) begin
            if (misaligned(cur_op) && (dmem_req || mmio_en))
                report_event("misaligned op raised a memory request");
            else if (in_mmio(cur_op.a) && dmem_req)
                report_event("MMIO op raised dmem_req");
            else if (xfer && in_mmio(cur_op.a) && !misaligned(cur_op) && !mmio_en)
                report_event("MMIO op left s3 without mmio_en");
        end
        if (xfer) begin
            e     = ref_apply(cur_op);
            e.cyc = cyc;
            exp_q.push_back(e);
            op_live = 1'b0;
        end
        if (wb_valid) check_wb();
    endtask

    // Drivers and responders change inputs on the falling edge only
    always @(negedge g_clk) begin
        if (running) begin
            cyc++;
            if (!op_live && op_q.size() != 0) begin
                cur_op  = op_q.pop_front();
                op_live = 1'b1;
            end
            s3_valid     = op_live;
            s3_rd        = cur_op.rd;
            s3_opr_a     = cur_op.a;
            s3_opr_b     = cur_op.b;
            s3_uop       = cur_op.uop;
            s3_fu        = cur_op.fu;
            hold_lsu_req = rand_stall && ($urandom_range(0, 3) == 0);
            dmem_gnt     = (gnt_wait == 0);
            dmem_recv    = (due_q.size() != 0) && (due_q[0] <= cyc);
            dmem_rdata   = dmem_recv ? rdata_q.pop_front() : $urandom;
            if (dmem_recv) void'(due_q.pop_front());
            mmio_rdata   = mmio_rd_pend ? dev_mmio[mmio_rd_idx] : $urandom;
            #8;
            sample_cycle();
        end
    end

    task automatic run_test(input string name, input int kind, input int count, input logic stall);
        int base_err;
        int waited;
        int i;
        test_name  = name;
        rand_stall = stall;
        lat_check  = (kind == 0);                    // Only pass-through runs stall free
        base_err   = errors;
        for (i = 0; i < count; i++) op_q.push_back(random_op(kind));
        waited = 0;
        while ((op_q.size() != 0 || op_live || exp_q.size() != 0) && waited < DRAIN_LIMIT) begin
            @(posedge g_clk);
            waited++;
        end
        if (waited >= DRAIN_LIMIT) begin
            $display("Timeout in %s: %0d results never came back", name, exp_q.size());
            timed_out = 1'b1;
        end
        tests_run++;
        if (errors != base_err || timed_out) tests_failed++;
        $display("Test %-12s %s  %0d ops, %0d errors", name,
                 (errors != base_err || timed_out) ? "FAIL" : "ok", count, errors - base_err);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        int seed;
        int i;
        seed     = 86994;
        void'($urandom(seed));
        g_resetn = 1'b0;
        for (i = 0; i < 16; i++) begin
            ref_mmio[i] = fill_word(MMIO_BASE_ADDR + xlen_t'(4 * i));
            dev_mmio[i] = ref_mmio[i];
        end
        repeat (16) @(posedge g_clk);
        #5;
        if (dmem_req !== 1'b0 || mmio_en !== 1'b0 || wb_valid !== 1'b0 || s3_busy !== 1'b0)
            report_event("outputs not idle during reset");
        @(negedge g_clk);
        g_resetn = 1'b1;
        @(posedge g_clk);
        running = 1'b1;
        run_test("pass_through", 0, 24, 1'b0);
        if (!timed_out) run_test("store_load", 1, 60, 1'b0);
        if (!timed_out) run_test("misaligned", 2, 24, 1'b0);
        if (!timed_out) run_test("mmio", 3, 32, 1'b0);
        if (!timed_out) run_test("random_mix", 4, 120, 1'b1);
        $display("Summary: %0d tests, %0d failed, %0d results checked, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !timed_out)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- source/mem_subsystem.sv
// Memory subsystem top: memory stage, pipeline register, response stage.
// No flush; order is kept end to end and wb_valid marks each result.

`timescale 1ns/100ps

module mem_subsystem import mem_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      s3_valid,
    input  reg_addr_t s3_rd,
    input  xlen_t     s3_opr_a,
    input  xlen_t     s3_opr_b,
    input  uop_t      s3_uop,
    input  fu_t       s3_fu,
    input  logic      s3_trap,
    output logic      s3_busy,
    input  logic      hold_lsu_req,
    output logic      dmem_req,
    output logic      dmem_wen,
    output strb_t     dmem_strb,
    output xlen_t     dmem_addr,
    output xlen_t     dmem_wdata,
    input  logic      dmem_gnt,
    input  logic      dmem_recv,
    input  xlen_t     dmem_rdata,
    output logic      mmio_en,
    output logic      mmio_wen,
    output xlen_t     mmio_addr,
    output xlen_t     mmio_wdata,
    input  xlen_t     mmio_rdata,
    output logic      wb_valid,
    output logic      wb_wen,
    output reg_addr_t wb_rd,
    output xlen_t     wb_wdata,
    output logic      wb_trap,
    output cause_t    wb_cause
);

    // Stage to pipeline register
    logic      p_valid;
    logic      p_busy;
    reg_addr_t n_rd;
    xlen_t     n_opr_a;
    xlen_t     n_opr_b;
    uop_t      n_uop;
    fu_t       n_fu;
    logic      n_trap;

    // Pipeline register to response stage
    logic      s4_valid;
    logic      s4_busy;
    reg_addr_t s4_rd;
    xlen_t     s4_opr_a;
    xlen_t     s4_opr_b;
    uop_t      s4_uop;
    fu_t       s4_fu;
    logic      s4_trap;

    mem_stage u_stage (
        .g_clk (g_clk), .g_resetn (g_resetn),
        .s3_valid (s3_valid), .s3_rd (s3_rd), .s3_opr_a (s3_opr_a),
        .s3_opr_b (s3_opr_b), .s3_uop (s3_uop), .s3_fu (s3_fu),
        .s3_trap (s3_trap), .hold_lsu_req (hold_lsu_req), .p_busy (p_busy),
        .dmem_gnt (dmem_gnt), .dmem_recv (dmem_recv), .s3_busy (s3_busy),
        .p_valid (p_valid), .n_rd (n_rd), .n_opr_a (n_opr_a),
        .n_opr_b (n_opr_b), .n_uop (n_uop), .n_fu (n_fu), .n_trap (n_trap),
        .dmem_req (dmem_req), .dmem_wen (dmem_wen), .dmem_strb (dmem_strb),
        .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata),
        .mmio_en (mmio_en), .mmio_wen (mmio_wen), .mmio_addr (mmio_addr),
        .mmio_wdata (mmio_wdata)
    );

    mem_pipe_reg u_pipe_reg (
        .g_clk (g_clk), .g_resetn (g_resetn),
        .p_valid (p_valid), .n_rd (n_rd), .n_opr_a (n_opr_a),
        .n_opr_b (n_opr_b), .n_uop (n_uop), .n_fu (n_fu), .n_trap (n_trap),
        .s4_busy (s4_busy), .p_busy (p_busy), .s4_rd (s4_rd),
        .s4_opr_a (s4_opr_a), .s4_opr_b (s4_opr_b), .s4_uop (s4_uop),
        .s4_fu (s4_fu), .s4_trap (s4_trap), .s4_valid (s4_valid)
    );

    mem_response u_response (
        .g_clk (g_clk), .g_resetn (g_resetn),
        .s4_rd (s4_rd), .s4_opr_a (s4_opr_a), .s4_opr_b (s4_opr_b),
        .s4_uop (s4_uop), .s4_fu (s4_fu), .s4_trap (s4_trap),
        .s4_valid (s4_valid), .dmem_recv (dmem_recv),
        .dmem_rdata (dmem_rdata), .mmio_rdata (mmio_rdata),
        .mmio_en (mmio_en), .mmio_wen (mmio_wen), .s4_busy (s4_busy),
        .wb_valid (wb_valid), .wb_wen (wb_wen), .wb_rd (wb_rd),
        .wb_wdata (wb_wdata), .wb_trap (wb_trap), .wb_cause (wb_cause)
    );

endmodule

//--- source/mem_response.sv
// Response stage. Relies on the memory stage letting at most one load's
// data be in flight ahead of its consumption by this stage.
// MMIO read data is taken one cycle after mmio_en, dmem data on dmem_recv.
// Writeback results are registered, one wb_valid pulse per instruction.

`timescale 1ns/100ps

module mem_response import mem_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  reg_addr_t s4_rd,
    input  xlen_t     s4_opr_a,
    input  xlen_t     s4_opr_b,     // Byte address for LSU ops
    input  uop_t      s4_uop,
    input  fu_t       s4_fu,
    input  logic      s4_trap,
    input  logic      s4_valid,
    input  logic      dmem_recv,
    input  xlen_t     dmem_rdata,
    input  xlen_t     mmio_rdata,
    input  logic      mmio_en,
    input  logic      mmio_wen,
    output logic      s4_busy,
    output logic      wb_valid,
    output logic      wb_wen,
    output reg_addr_t wb_rd,
    output xlen_t     wb_wdata,
    output logic      wb_trap,
    output cause_t    wb_cause
);

    resp_state_e resp_state;
    logic        s4_lsu;
    logic        s4_load;
    logic        need_data;
    logic        accept;
    logic        mmio_rd_q;    // MMIO read data due this cycle
    logic        data_valid;
    logic [1:0]  size;
    logic        sign;
    xlen_t       hold_data;
    xlen_t       shifted;
    xlen_t       load_val;

    assign s4_lsu    = s4_fu == FU_LSU;
    assign s4_load   = s4_lsu && s4_uop[UOP_LOAD] && !s4_trap;
    assign need_data = s4_valid && s4_load;
    assign s4_busy   = need_data && (resp_state == RESP_IDLE || !data_valid);
    assign accept    = s4_valid && !s4_busy;

    // ------------------------------------------------------------------
    // Load data capture
    // ------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mmio_rd_q  <= 1'b0;
            data_valid <= 1'b0;
            resp_state <= RESP_IDLE;
        end else begin
            mmio_rd_q <= mmio_en && !mmio_wen;
            if (dmem_recv || mmio_rd_q) begin
                data_valid <= 1'b1;
            end else if (accept && s4_load) begin
                data_valid <= 1'b0;                    // Consumed
            end
            case (resp_state)
                RESP_IDLE:      if (need_data) resp_state <= RESP_WAIT_DATA;
                RESP_WAIT_DATA: if (data_valid) resp_state <= RESP_IDLE;
                default:        resp_state <= RESP_IDLE;
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (dmem_recv) begin
            hold_data <= dmem_rdata;
        end else if (mmio_rd_q) begin
            hold_data <= mmio_rdata;
        end
    end

    // ------------------------------------------------------------------
    // Align and extend
    // ------------------------------------------------------------------

    assign size    = s4_uop[UOP_SIZE_LO +: 2];
    assign sign    = s4_uop[UOP_SIGNED];
    assign shifted = hold_data >> {s4_opr_b[1:0], 3'b000}; // Lane to bit 0

    always_comb begin
        case (size)
            LSU_BYTE: load_val = {{24{sign && shifted[7]}}, shifted[7:0]};
            LSU_HALF: load_val = {{16{sign && shifted[15]}}, shifted[15:0]};
            default:  load_val = shifted;
        endcase
    end

    // ------------------------------------------------------------------
    // Writeback
    // ------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= accept;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            wb_wen   <= s4_load || (!s4_lsu && !s4_trap); // Stores write nothing
            wb_rd    <= s4_trap ? '0 : s4_rd;
            wb_wdata <= s4_lsu ? (s4_load ? load_val : '0) : s4_opr_a;
            wb_trap  <= s4_trap;
            wb_cause <= s4_trap ? s4_rd : '0;             // Cause came in rd
        end
    end

endmodule

//--- source/mem_pipe_reg.sv
// Single entry pipeline register with valid/busy flow control.
// Takes a new item in the same cycle it hands one on.

`timescale 1ns/100ps

module mem_pipe_reg import mem_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      p_valid,
    input  reg_addr_t n_rd,
    input  xlen_t     n_opr_a,
    input  xlen_t     n_opr_b,
    input  uop_t      n_uop,
    input  fu_t       n_fu,
    input  logic      n_trap,
    input  logic      s4_busy,
    output logic      p_busy,
    output reg_addr_t s4_rd,
    output xlen_t     s4_opr_a,
    output xlen_t     s4_opr_b,
    output uop_t      s4_uop,
    output fu_t       s4_fu,
    output logic      s4_trap,
    output logic      s4_valid
);

    assign p_busy = s4_valid && s4_busy; // Full and not draining

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s4_valid <= 1'b0;
        end else if (!p_busy) begin
            s4_valid <= p_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (p_valid && !p_busy) begin
            s4_rd    <= n_rd;
            s4_opr_a <= n_opr_a;
            s4_opr_b <= n_opr_b;
            s4_uop   <= n_uop;
            s4_fu    <= n_fu;
            s4_trap  <= n_trap;
        end
    end

endmodule

//--- source/mem_stage.sv
// Memory stage. Execute must hold its s3 inputs while s3_busy is high.
// An LSU request only starts while the pipeline register can take the
// op, so a granted access always leaves s3 in its completion cycle.
// A trap already raised by execute keeps its cause in s3_rd.

`timescale 1ns/100ps

module mem_stage import mem_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      s3_valid,
    input  reg_addr_t s3_rd,
    input  xlen_t     s3_opr_a,     // Address or result
    input  xlen_t     s3_opr_b,     // Store data
    input  uop_t      s3_uop,
    input  fu_t       s3_fu,
    input  logic      s3_trap,
    input  logic      hold_lsu_req,
    input  logic      p_busy,
    input  logic      dmem_gnt,
    input  logic      dmem_recv,
    output logic      s3_busy,
    output logic      p_valid,
    output reg_addr_t n_rd,
    output xlen_t     n_opr_a,
    output xlen_t     n_opr_b,
    output uop_t      n_uop,
    output fu_t       n_fu,
    output logic      n_trap,
    output logic      dmem_req,
    output logic      dmem_wen,
    output strb_t     dmem_strb,
    output xlen_t     dmem_addr,
    output xlen_t     dmem_wdata,
    output logic      mmio_en,
    output logic      mmio_wen,
    output xlen_t     mmio_addr,
    output xlen_t     mmio_wdata
);

    logic   fu_lsu;
    logic   lsu_valid;
    logic   lsu_ready;
    logic   lsu_a_error;
    logic   lsu_mmio;
    logic   lsu_hold;
    logic   lsu_trap;
    cause_t lsu_cause;

    // ------------------------------------------------------------------
    // Decode and stalling
    // ------------------------------------------------------------------

    assign fu_lsu    = s3_fu == FU_LSU;
    assign lsu_valid = s3_valid && fu_lsu && !s3_trap; // Trapped ops skip memory
    assign lsu_hold  = hold_lsu_req || p_busy;         // Start only if s4 side free

    assign s3_busy = p_busy || (lsu_valid && !lsu_ready);
    assign p_valid = s3_valid && !s3_busy;

    // ------------------------------------------------------------------
    // Trap selection
    // ------------------------------------------------------------------

    assign lsu_trap  = lsu_valid && lsu_a_error;
    assign lsu_cause = s3_uop[UOP_LOAD] ? TRAP_LDALIGN : TRAP_STALIGN;

    assign n_trap = s3_trap || lsu_trap;
    assign n_rd   = lsu_trap ? lsu_cause : s3_rd;      // Cause rides in rd

    // ------------------------------------------------------------------
    // Next stage values
    // ------------------------------------------------------------------

    // LSU ops carry {mmio, strb} in A and the byte address in B
    assign n_opr_a = lsu_valid ? {27'b0, lsu_mmio, dmem_strb} : s3_opr_a;
    assign n_opr_b = lsu_valid ? s3_opr_a : s3_opr_b;
    assign n_uop   = s3_uop;
    assign n_fu    = s3_fu;

    mem_lsu u_lsu (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .lsu_valid    (lsu_valid),
        .lsu_addr     (s3_opr_a),
        .lsu_wdata    (s3_opr_b),
        .lsu_uop      (s3_uop),
        .hold_lsu_req (lsu_hold),
        .dmem_gnt     (dmem_gnt),
        .dmem_recv    (dmem_recv),
        .lsu_ready    (lsu_ready),
        .lsu_a_error  (lsu_a_error),
        .lsu_mmio     (lsu_mmio),
        .dmem_req     (dmem_req),
        .dmem_wen     (dmem_wen),
        .dmem_strb    (dmem_strb),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .mmio_en      (mmio_en),
        .mmio_wen     (mmio_wen),
        .mmio_addr    (mmio_addr),
        .mmio_wdata   (mmio_wdata)
    );

endmodule

//--- source/mem_lsu.sv
// Load/store unit. Inputs must stay steady while an access is pending.
// Only one data memory load may be outstanding; all new requests wait
// for its dmem_recv. Misaligned ops complete at once without a request.
// dmem_addr and mmio_addr are word aligned, lanes chosen by dmem_strb.

`timescale 1ns/100ps

module mem_lsu import mem_pkg::*; (
    input  logic   g_clk,
    input  logic   g_resetn,
    input  logic   lsu_valid,    // LSU op present
    input  xlen_t  lsu_addr,     // Byte address
    input  xlen_t  lsu_wdata,    // Store data, low aligned
    input  uop_t   lsu_uop,
    input  logic   hold_lsu_req, // Block new requests
    input  logic   dmem_gnt,
    input  logic   dmem_recv,
    output logic   lsu_ready,    // Op complete this cycle
    output logic   lsu_a_error,  // Misaligned access
    output logic   lsu_mmio,     // Address in MMIO page
    output logic   dmem_req,
    output logic   dmem_wen,
    output strb_t  dmem_strb,
    output xlen_t  dmem_addr,
    output xlen_t  dmem_wdata,
    output logic   mmio_en,
    output logic   mmio_wen,
    output xlen_t  mmio_addr,
    output xlen_t  mmio_wdata
);

    lsu_state_e lsu_state;
    logic [1:0] size;
    logic       is_load;
    logic       is_store;
    logic       misaligned;
    logic       can_issue;
    logic       dmem_done;
    xlen_t      wdata_rep;

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------

    assign size     = lsu_uop[UOP_SIZE_LO +: 2];
    assign is_load  = lsu_uop[UOP_LOAD];
    assign is_store = lsu_uop[UOP_STORE];

    always_comb begin
        case (size)
            LSU_BYTE: misaligned = 1'b0;
            LSU_HALF: misaligned = lsu_addr[0];
            default:  misaligned = |lsu_addr[1:0]; // Word, and unused code
        endcase
    end

    assign lsu_a_error = lsu_valid && misaligned;
    assign lsu_mmio    = (lsu_addr & MMIO_BASE_MASK) == MMIO_BASE_ADDR;

    // Byte lanes and replicated store data
    always_comb begin
        case (size)
            LSU_BYTE: begin
                dmem_strb = strb_t'(4'b0001 << lsu_addr[1:0]);
                wdata_rep = {4{lsu_wdata[7:0]}};
            end
            LSU_HALF: begin
                dmem_strb = lsu_addr[1] ? 4'b1100 : 4'b0011;
                wdata_rep = {2{lsu_wdata[15:0]}};
            end
            default: begin
                dmem_strb = 4'b1111;
                wdata_rep = lsu_wdata;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // Request FSM
    // ------------------------------------------------------------------

    // Fresh requests only from IDLE, which also covers the load guard
    assign can_issue = lsu_valid && !misaligned && !hold_lsu_req &&
                       (lsu_state == LSU_IDLE);

    assign dmem_req   = (lsu_state == LSU_REQ) || (can_issue && !lsu_mmio);
    assign dmem_wen   = is_store;
    assign dmem_addr  = {lsu_addr[31:2], 2'b00};
    assign dmem_wdata = wdata_rep;
    assign dmem_done  = dmem_req && dmem_gnt;

    assign mmio_en    = can_issue && lsu_mmio; // No grant, done at once
    assign mmio_wen   = is_store;
    assign mmio_addr  = {lsu_addr[31:2], 2'b00};
    assign mmio_wdata = wdata_rep;

    assign lsu_ready  = lsu_valid && (misaligned || mmio_en || dmem_done);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lsu_state <= LSU_IDLE;
        end else begin
            case (lsu_state)
                LSU_IDLE, LSU_REQ: begin
                    if (dmem_done) begin
                        lsu_state <= is_load ? LSU_WAIT_DONE : LSU_IDLE;
                    end else if (dmem_req) begin
                        lsu_state <= LSU_REQ;          // Hold until gnt
                    end
                end
                LSU_WAIT_DONE: begin
                    if (dmem_recv) begin
                        lsu_state <= LSU_IDLE;         // Load data back
                    end
                end
                default: lsu_state <= LSU_IDLE;
            endcase
        end
    end

endmodule

//--- source/mem_pkg.sv
// Shared types and constants for the memory stage subsystem.
// Micro-op layout: bit 0 load, bit 1 store, bits 3:2 size, bit 4 signed.
// The MMIO region is one 4 KiB page; anything else goes to data memory.

package mem_pkg;

    typedef logic [31:0] xlen_t;     // Data or address word
    typedef logic [ 4:0] reg_addr_t; // Register index
    typedef logic [ 4:0] uop_t;      // Micro-op code
    typedef logic        fu_t;       // 1 = LSU, 0 = pass-through
    typedef logic [ 3:0] strb_t;     // Byte write strobe
    typedef logic [ 4:0] cause_t;    // Trap cause

    // Micro-op field positions
    localparam int UOP_LOAD    = 0;
    localparam int UOP_STORE   = 1;
    localparam int UOP_SIZE_LO = 2; // Two-bit size field starts here
    localparam int UOP_SIGNED  = 4;

    // Access size codes
    localparam logic [1:0] LSU_BYTE = 2'd0;
    localparam logic [1:0] LSU_HALF = 2'd1;
    localparam logic [1:0] LSU_WORD = 2'd2;

    localparam fu_t FU_LSU = 1'b1;

    // Alignment trap causes
    localparam cause_t TRAP_LDALIGN = 5'd4;
    localparam cause_t TRAP_STALIGN = 5'd6;

    // MMIO page decode
    localparam xlen_t MMIO_BASE_ADDR = 32'h0000_1000;
    localparam xlen_t MMIO_BASE_MASK = 32'hFFFF_F000;

    // LSU request FSM, WAIT_DONE means a load is outstanding
    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_REQ,
        LSU_WAIT_DONE
    } lsu_state_e;

    // Response stage FSM
    typedef enum logic {
        RESP_IDLE,
        RESP_WAIT_DATA
    } resp_state_e;

endpackage
